// File: run.sh
#!/bin/sh
# Build the loader testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module tb_nes_loader -o tb_nes_loader

./obj_dir/tb_nes_loader > sim.log
cat sim.log

grep -F -q "** PASS **" sim.log

// File: tb.f
+incdir+verilog
verilog/rom_pkg.sv
verilog/input_pkg.sv
verilog/ines_info_if.sv
verilog/ines_header.sv
verilog/rom_loader.sv
verilog/joypad_serial.sv
verilog/cheat_code_collector.sv
verilog/nes_loader_top.sv
tests/tb_nes_loader.sv

// File: tests/loader_input.txt
# img: header bytes 0-15, invert_mirroring, expected mapper_flags, expected error
# cht: record bytes 0-15; joy: joy_a joy_b in host order; all values hex
# one PRG page, no CHR, mapper 1, vertical mirroring, saves
img 4E 45 53 1A 01 00 13 00 00 00 00 00 00 00 00 00 0 0200C001 0
# one PRG page and one CHR page, mirroring inverted
img 4E 45 53 1A 01 01 20 00 00 00 00 00 00 00 00 00 1 00004002 0
# bad magic byte
img 4E 45 53 00 01 00 00 00 00 00 00 00 00 00 00 00 0 00008000 1
# trainer bit set, four-screen
img 4E 45 53 1A 01 00 0C 00 00 00 00 00 00 00 00 00 0 00018000 1
# dirty header, upper mapper nibble dropped
img 4E 45 53 1A 01 00 40 10 05 00 00 00 44 69 73 6B 0 00008004 0
# NES 2.0 header, two PRG pages, submapper 3
img 4E 45 53 1A 02 00 50 18 03 00 07 00 00 00 00 00 0 00068115 0
# cheat records: flags, address, compare, replace, low byte first
cht 01 00 00 00 34 12 00 00 00 00 00 00 A9 00 00 00
cht 03 00 00 00 10 80 00 00 05 00 00 00 FF 00 00 00
# controller vectors
joy 01 80
joy 5A C3
joy FF 00

// File: tests/tb_nes_loader.sv
/*
 * Testbench for the cartridge loading path. Loads the iNES images, cheat
 * records and controller vectors in tests/loader_input.txt and checks the DUT
 */
`timescale 1ns/100ps
`default_nettype none
`include "nes_macros.svh"

module tb_nes_loader;
	import rom_pkg::*;
	import input_pkg::*;

	logic          clk;
	logic          reset_nes;
	logic          byte_strobe;
	rom_byte_t     byte_data;
	cheat_index_t  byte_index;
	rom_byte_t     filetype;
	logic          invert_mirroring;
	mem_addr_t     mem_addr;
	rom_byte_t     mem_data;
	logic          mem_write;
	logic          loader_busy;
	logic          loader_done;
	logic          loader_error;
	mapper_flags_t mapper_flags;
	cheat_code_t   cheat_code;
	logic          cheat_valid;
	joy_buttons_t  joy_a;
	joy_buttons_t  joy_b;
	logic          joy_swap;
	logic          joypad_strobe;
	logic [1:0]    joypad_clock;
	logic [1:0]    joypad_data;

	// Records from the input file
	rom_byte_t     img_hdr [0:7][0:15];
	logic          img_inv [0:7];
	mapper_flags_t img_flags [0:7];
	logic          img_err [0:7];
	rom_byte_t     cheat_rec [0:3][0:15];
	joy_buttons_t  vec_a [0:7];
	joy_buttons_t  vec_b [0:7];
	int            num_img;
	int            num_cheat;
	int            num_vec;

	rom_byte_t payload [0:65535]; // Bytes streamed after the header
	int        write_count;
	int        writes_expected;
	int        prg_len_now;
	int        cheat_pulses;
	int        error_count;
	int        check_count;
	int        cycle_count;
	int        timeout_limit = 2000;
	integer    seed = 57;

	nes_loader_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [127:0] got,
	                           input logic [127:0] expected);
		check_count++;
		if (got !== expected) begin
			$display("ERR %0t %s: got %0h, expected %0h", $time, name, got, expected);
			error_count++;
		end
	endtask

	// PRG from PRG_BASE, CHR right after it from CHR_BASE
	function automatic mem_addr_t expected_addr(input int k);
		if (k < prg_len_now)
			return mem_addr_t'(`PRG_BASE + k);
		return mem_addr_t'(`CHR_BASE + (k - prg_len_now));
	endfunction

	// Serial order A, B, select, start, up, down, left, right
	function automatic logic button_at(input joy_buttons_t btn, input int k);
		case (k)
			0: return btn[4];
			1: return btn[5];
			2: return btn[6];
			3: return btn[7];
			4: return btn[3];
			5: return btn[2];
			6: return btn[1];
			default: return btn[0];
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Monitors
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_limit);
			$display("** FAIL **");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (!reset_nes && cheat_valid)
			cheat_pulses++;
		if (!reset_nes && mem_write) begin
			if (write_count >= writes_expected) begin
				$display("Unexpected memory write to %0h at %0t", mem_addr, $time);
				error_count++;
			end else begin
				check_value("mem_addr", mem_addr, expected_addr(write_count));
				check_value("mem_data", mem_data, payload[write_count]);
			end
			write_count++;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic apply_reset;
		@(negedge clk);
		reset_nes = 1'b1;
		repeat (16) @(negedge clk);
		reset_nes = 1'b0;
	endtask

	task automatic send_byte(input rom_byte_t value, input int pos);
		@(negedge clk);
		byte_strobe = 1'b1;
		byte_data   = value;
		byte_index  = cheat_index_t'(pos); // Low 4 bits of the file position
		@(negedge clk);
		byte_strobe = 1'b0;
	endtask

	task automatic read_input_file(input int fd);
		logic [63:0]   tag;
		logic [1023:0] rest;
		logic [31:0]   value;
		int            k;
		int            bytes;
		forever begin
			tag = '0;
			if ($fscanf(fd, "%s", tag) != 1)
				break;
			if (tag == "#") begin
				void'($fgets(rest, fd));
			end else if (tag == "img") begin
				for (k = 0; k < 16; k++) begin
					void'($fscanf(fd, "%h", value));
					img_hdr[num_img][k] = rom_byte_t'(value);
				end
				void'($fscanf(fd, "%h", value));
				img_inv[num_img] = value[0];
				void'($fscanf(fd, "%h", value));
				img_flags[num_img] = value;
				void'($fscanf(fd, "%h", value));
				img_err[num_img] = value[0];
				bytes = value[0] ? 32 : (int'(img_hdr[num_img][4]) << `PRG_PAGE_SHIFT) +
				                        (int'(img_hdr[num_img][5]) << `CHR_PAGE_SHIFT);
				timeout_limit += (16 + bytes) * 2;
				num_img++;
			end else if (tag == "cht") begin
				for (k = 0; k < 16; k++) begin
					void'($fscanf(fd, "%h", value));
					cheat_rec[num_cheat][k] = rom_byte_t'(value);
				end
				num_cheat++;
			end else if (tag == "joy") begin
				void'($fscanf(fd, "%h", value));
				vec_a[num_vec] = joy_buttons_t'(value);
				void'($fscanf(fd, "%h", value));
				vec_b[num_vec] = joy_buttons_t'(value);
				num_vec++;
			end else begin
				$display("Unknown record type in the input file");
				error_count++;
				void'($fgets(rest, fd));
			end
		end
	endtask

	task automatic load_image(input int n);
		int k;
		int chr_len;
		int total;
		int waited;
		prg_len_now = int'(img_hdr[n][4]) << `PRG_PAGE_SHIFT;
		chr_len     = int'(img_hdr[n][5]) << `CHR_PAGE_SHIFT;
		total       = img_err[n] ? 32 : prg_len_now + chr_len; // Bad images get a few bytes
		for (k = 0; k < total; k++)
			payload[k] = rom_byte_t'($random(seed));
		apply_reset();
		invert_mirroring = img_inv[n];
		write_count      = 0;
		writes_expected  = img_err[n] ? 0 : total;
		for (k = 0; k < 16; k++)
			send_byte(img_hdr[n][k], k);
		waited = 0;
		while (!loader_busy && !loader_done && waited < 2) begin
			@(negedge clk);
			waited++;
		end
		check_value("loader_busy", loader_busy, !img_err[n]);
		check_value("loader_done", loader_done, img_err[n]);
		check_value("mapper_flags", mapper_flags, img_flags[n]);
		for (k = 0; k < total; k++)
			send_byte(payload[k], 16 + k);
		waited = 0;
		while (!loader_done && waited < 2) begin
			@(negedge clk);
			waited++;
		end
		check_value("loader_done", loader_done, 1'b1);
		check_value("loader_busy", loader_busy, 1'b0);
		check_value("loader_error", loader_error, img_err[n]);
		check_value("write_count", write_count, writes_expected);
	endtask

	task automatic send_cheat(input int n);
		cheat_code_t expected;
		int          k;
		int          waited;
		// Flags field on top, each field low byte first
		for (k = 0; k < 16; k++)
			expected[32 * (3 - k / 4) + 8 * (k % 4) +: 8] = cheat_rec[n][k];
		for (k = 0; k < 16; k++)
			send_byte(cheat_rec[n][k], k);
		waited = 0;
		while (!cheat_valid && waited < 2) begin
			@(negedge clk);
			waited++;
		end
		check_value("cheat_valid", cheat_valid, 1'b1);
		check_value("cheat_code", cheat_code, expected);
		@(negedge clk);
		check_value("cheat_valid", cheat_valid, 1'b0);
		check_value("cheat_pulses", cheat_pulses, n + 1);
	endtask

	task automatic read_joypads(input joy_buttons_t a, input joy_buttons_t b,
	                            input logic swap);
		joy_buttons_t port_buttons [2];
		logic         expected;
		int           k;
		int           n;
		port_buttons[0] = swap ? b : a;
		port_buttons[1] = swap ? a : b;
		@(negedge clk);
		joy_a         = a;
		joy_b         = b;
		joy_swap      = swap;
		joypad_strobe = 1'b1;
		@(negedge clk);
		joypad_strobe = 1'b0;
		for (k = 0; k < 26; k++) begin
			for (n = 0; n < 2; n++) begin
				expected = (k < 8) ? button_at(port_buttons[n], k) : (k < 24); // Ones, then zeros
				check_value($sformatf("joypad_data[%0d]", n), joypad_data[n], expected);
			end
			joypad_clock = 2'b11;
			@(negedge clk);
			joypad_clock = 2'b00;
			@(negedge clk);
		end
	endtask

	initial begin
		int fd;
		int n;
		reset_nes        = 1'b1;
		byte_strobe      = 1'b0;
		byte_data        = '0;
		byte_index       = '0;
		filetype         = 8'h01;
		invert_mirroring = 1'b0;
		joy_a            = '0;
		joy_b            = '0;
		joy_swap         = 1'b0;
		joypad_strobe    = 1'b0;
		joypad_clock     = 2'b00;
		fd = $fopen("tests/loader_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open tests/loader_input.txt");
			error_count++;
		end else begin
			read_input_file(fd);
			$fclose(fd);
			if (num_img == 0 || num_cheat == 0 || num_vec == 0) begin
				$display("The input file is missing images, cheat records or vectors");
				error_count++;
			end
			apply_reset();
			for (n = 0; n < num_img; n++)
				load_image(n);
			apply_reset();
			filetype        = `CHEAT_FILETYPE;
			write_count     = 0;
			writes_expected = 0;
			cheat_pulses    = 0;
			for (n = 0; n < num_cheat; n++)
				send_cheat(n);
			check_value("write_count", write_count, 0);
			check_value("loader_busy", loader_busy, 1'b0);
			filetype = 8'h01;
			for (n = 0; n < num_vec; n++) begin
				read_joypads(vec_a[n], vec_b[n], 1'b0);
				read_joypads(vec_a[n], vec_b[n], 1'b1);
			end
		end
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/cheat_code_collector.sv
/*
 * Builds 128-bit cheat codes from 16-byte records. Each 32-bit field
 * arrives low byte first; valid pulses after byte 15
 */
`timescale 1ns/100ps
`default_nettype none

module cheat_code_collector (
	input  logic                    clk,
	input  logic                    reset_nes,
	input  logic                    byte_strobe,
	input  rom_pkg::rom_byte_t      byte_data,
	input  input_pkg::cheat_index_t byte_index,
	output input_pkg::cheat_code_t  cheat_code,
	output logic                    cheat_valid
);

	logic [6:0] byte_pos;

	// Field 0 (flags) sits at the top, so the field number is inverted
	assign byte_pos = {~byte_index[3:2], byte_index[1:0], 3'b000};

	always_ff @(posedge clk) begin
		if (reset_nes)
			cheat_code <= '0;
		else if (byte_strobe)
			cheat_code[byte_pos +: 8] <= byte_data;
	end

	always_ff @(posedge clk) begin
		if (reset_nes)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= byte_strobe && (byte_index == 4'd15); // Record complete
	end

endmodule

`default_nettype wire

// File: verilog/ines_header.sv
/*
 * Captures the 16-byte iNES header, checks magic and trainer bit and
 * decodes page counts and the mapper flags word for the loader
 */
`timescale 1ns/100ps
`default_nettype none
`include "nes_macros.svh"

module ines_header (
	input  logic                   clk,
	input  logic                   reset_nes,
	input  logic                   byte_strobe,
	input  rom_pkg::rom_byte_t     byte_data,
	input  logic                   invert_mirroring,
	output rom_pkg::mapper_flags_t mapper_flags,
	ines_info_if.source            info
);
	import rom_pkg::*;

	rom_byte_t  ines [0:15];
	logic [4:0] hdr_count;  // Saturates at 16
	logic       done_seen;
	logic       magic_ok;
	logic       is_nes20;
	logic       is_dirty;
	logic [7:0] mapper;

	// Smallest power-of-two page code that covers the count
	function automatic size_code_t size_code(input page_count_t pages);
		size_code_t code;
		code = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (pages <= (9'd1 << i))
				code = size_code_t'(i);
		end
		return code;
	endfunction

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			for (int i = 0; i < 16; i++)
				ines[i] <= '0;
		end else if (byte_strobe && !hdr_count[4]) begin
			ines[hdr_count[3:0]] <= byte_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			hdr_count        <= '0;
			info.header_done <= 1'b0;
			info.header_ok   <= 1'b0;
			done_seen        <= 1'b0;
		end else begin
			info.header_done <= byte_strobe && (hdr_count == 5'd15);
			if (byte_strobe && !hdr_count[4]) begin
				hdr_count <= hdr_count + 5'd1;
				if (hdr_count == 5'd15)
					info.header_ok <= magic_ok && !ines[6][2]; // No trainer support
			end
			if (info.header_done)
				done_seen <= 1'b1;
		end
	end

	assign magic_ok = (ines[0] == `INES_MAGIC0) && (ines[1] == `INES_MAGIC1) &&
	                  (ines[2] == `INES_MAGIC2) && (ines[3] == `INES_MAGIC3);
	assign is_nes20 = (ines[7][3:2] == 2'b10);
	// Junk in bytes 9-15 of an old header poisons the upper mapper nibble
	assign is_dirty = !is_nes20 &&
	                  (|{ines[9], ines[10], ines[11], ines[12], ines[13], ines[14], ines[15]});
	assign mapper   = {is_dirty ? 4'h0 : ines[7][7:4], ines[6][7:4]};

	assign info.prg_pages = ines[4];
	assign info.chr_pages = ines[5];

	always_comb begin
		mapper_flags = '0;
		mapper_flags[`MF_MAPPER_LO +: 8]    = mapper;
		mapper_flags[`MF_PRG_SIZE_LO +: 3]  = size_code(ines[4]);
		mapper_flags[`MF_CHR_SIZE_LO +: 3]  = size_code(ines[5]);
		mapper_flags[`MF_MIRROR]            = ines[6][0] ^ invert_mirroring;
		mapper_flags[`MF_CHR_RAM]           = (ines[5] == 8'd0);
		mapper_flags[`MF_FOUR_SCREEN]       = ines[6][3];
		mapper_flags[`MF_SUBMAPPER_LO +: 8] = is_nes20 ? ines[8] : 8'h00;
		mapper_flags[`MF_HAS_SAVES]         = ines[6][1];
	end

	// One verdict per image
	a_single_verdict: assert property (@(posedge clk) disable iff (reset_nes)
		info.header_done |-> !done_seen);

endmodule

`default_nettype wire

// File: verilog/ines_info_if.sv
/*
 * Header verdict handed from the iNES header parser to the ROM loader
 */
`timescale 1ns/100ps
`default_nettype none

interface ines_info_if;
	import rom_pkg::*;

	logic        header_done; // One cycle after the 16th header byte
	logic        header_ok;   // Held until reset
	page_count_t prg_pages;
	page_count_t chr_pages;

	modport source (output header_done, output header_ok, output prg_pages, output chr_pages);
	modport sink (input header_done, input header_ok, input prg_pages, input chr_pages);

endinterface

`default_nettype wire

// File: verilog/input_pkg.sv
/*
 * Types for controller buttons and cheat records
 */
`default_nettype none

package input_pkg;

	// Host order, bit 0 up to bit 7: right, left, down, up, A, B, select, start
	typedef logic [7:0]  joy_buttons_t;
	typedef logic [23:0] joy_shift_t;
	typedef logic [3:0]  cheat_index_t;

	// {flags, address, compare, replace}, 32 bits each
	typedef logic [127:0] cheat_code_t;

endpackage

`default_nettype wire

// File: verilog/joypad_serial.sv
/*
 * Two controller port shift registers. Parallel load while strobe is
 * high, one shift per falling edge of each port's clock
 */
`timescale 1ns/100ps
`default_nettype none

module joypad_serial (
	input  logic                    clk,
	input  logic                    reset_nes,
	input  input_pkg::joy_buttons_t joy_a,
	input  input_pkg::joy_buttons_t joy_b,
	input  logic                    joy_swap,
	input  logic                    joypad_strobe,
	input  logic [1:0]              joypad_clock,
	output logic [1:0]              joypad_data
);
	import input_pkg::*;

	joy_shift_t   shift_reg [2];
	joy_buttons_t port_btn [2];
	logic [1:0]   last_clock;

	// Host order to serial order A, B, select, start, up, down, left, right
	function automatic joy_buttons_t to_serial(input joy_buttons_t btn);
		return {btn[0], btn[1], btn[2], btn[3], btn[7], btn[6], btn[5], btn[4]};
	endfunction

	assign port_btn[0] = joy_swap ? joy_b : joy_a;
	assign port_btn[1] = joy_swap ? joy_a : joy_b;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			shift_reg[0] <= '0;
			shift_reg[1] <= '0;
			last_clock   <= '0;
		end else begin
			last_clock <= joypad_clock;
			for (int n = 0; n < 2; n++) begin
				if (joypad_strobe)
					shift_reg[n] <= {16'hFFFF, to_serial(port_btn[n])}; // Ones after button 8
				else if (last_clock[n] && !joypad_clock[n])
					shift_reg[n] <= {1'b0, shift_reg[n][23:1]};
			end
		end
	end

	assign joypad_data = {shift_reg[1][0], shift_reg[0][0]};

endmodule

`default_nettype wire

// File: verilog/nes_loader_top.sv
/*
 * Cartridge loading path: iNES header check, ROM streaming to memory,
 * cheat record collection and the two controller ports
 */
`timescale 1ns/100ps
`default_nettype none
`include "nes_macros.svh"

module nes_loader_top (
	input  logic                    clk,
	input  logic                    reset_nes,
	input  logic                    byte_strobe,
	input  rom_pkg::rom_byte_t      byte_data,
	input  input_pkg::cheat_index_t byte_index,
	input  rom_pkg::rom_byte_t      filetype,
	input  logic                    invert_mirroring,
	output rom_pkg::mem_addr_t      mem_addr,
	output rom_pkg::rom_byte_t      mem_data,
	output logic                    mem_write,
	output logic                    loader_busy,
	output logic                    loader_done,
	output logic                    loader_error,
	output rom_pkg::mapper_flags_t  mapper_flags,
	output input_pkg::cheat_code_t  cheat_code,
	output logic                    cheat_valid,
	input  input_pkg::joy_buttons_t joy_a,
	input  input_pkg::joy_buttons_t joy_b,
	input  logic                    joy_swap,
	input  logic                    joypad_strobe,
	input  logic [1:0]              joypad_clock,
	output logic [1:0]              joypad_data
);

	logic is_cheat;
	logic cheat_strobe;
	logic rom_strobe;

	ines_info_if info ();

	// Cheat files bypass the ROM path entirely
	assign is_cheat     = (filetype == `CHEAT_FILETYPE);
	assign cheat_strobe = byte_strobe && is_cheat;
	assign rom_strobe   = byte_strobe && !is_cheat;

	ines_header u_header (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.byte_strobe      (rom_strobe),
		.byte_data        (byte_data),
		.invert_mirroring (invert_mirroring),
		.mapper_flags     (mapper_flags),
		.info             (info.source)
	);

	rom_loader u_loader (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.byte_strobe (rom_strobe),
		.byte_data   (byte_data),
		.info        (info.sink),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data),
		.mem_write   (mem_write),
		.busy        (loader_busy),
		.done        (loader_done),
		.error       (loader_error)
	);

	cheat_code_collector u_cheat (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.byte_strobe (cheat_strobe),
		.byte_data   (byte_data),
		.byte_index  (byte_index),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	joypad_serial u_joypad (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.joy_a         (joy_a),
		.joy_b         (joy_b),
		.joy_swap      (joy_swap),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.joypad_data   (joypad_data)
	);

endmodule

`default_nettype wire

// File: verilog/nes_macros.svh
/*
 * Constants for the cartridge loading path: iNES magic bytes, the cheat
 * file type, memory region bases and the mapper flag bit layout
 */
`ifndef NES_MACROS_SVH
`define NES_MACROS_SVH

// iNES signature "NES" + EOF
`define INES_MAGIC0      8'h4E
`define INES_MAGIC1      8'h45
`define INES_MAGIC2      8'h53
`define INES_MAGIC3      8'h1A
`define CHEAT_FILETYPE   8'hFF

`define PRG_BASE         22'h000000
`define CHR_BASE         22'h200000 // CHR lives in the upper half
`define PRG_PAGE_SHIFT   14         // 16 KB pages
`define CHR_PAGE_SHIFT   13         // 8 KB pages

// Mapper flags word layout
`define MF_MAPPER_LO     0
`define MF_PRG_SIZE_LO   8
`define MF_CHR_SIZE_LO   11
`define MF_MIRROR        14
`define MF_CHR_RAM       15
`define MF_FOUR_SCREEN   16
`define MF_SUBMAPPER_LO  17
`define MF_HAS_SAVES     25

`endif

// File: verilog/rom_loader.sv
/*
 * Streams PRG then CHR bytes to the flat memory port once the header
 * verdict is in. One write per byte strobe at the running address
 */
`timescale 1ns/100ps
`default_nettype none
`include "nes_macros.svh"

module rom_loader (
	input  logic               clk,
	input  logic               reset_nes,
	input  logic               byte_strobe,
	input  rom_pkg::rom_byte_t byte_data,
	ines_info_if.sink          info,
	output rom_pkg::mem_addr_t mem_addr,
	output rom_pkg::rom_byte_t mem_data,
	output logic               mem_write,
	output logic               busy,
	output logic               done,
	output logic               error
);
	import rom_pkg::*;

	load_state_t state;
	byte_count_t bytes_left;
	byte_count_t prg_bytes;
	byte_count_t chr_bytes;

	assign prg_bytes = byte_count_t'(info.prg_pages) << `PRG_PAGE_SHIFT;
	assign chr_bytes = byte_count_t'(info.chr_pages) << `CHR_PAGE_SHIFT;

	//////////////////////////////////////////////////
	// Load FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= LOAD_HEADER;
			bytes_left <= '0;
			mem_addr   <= `PRG_BASE;
		end else begin
			case (state)
				LOAD_HEADER: if (info.header_done) begin
					mem_addr <= `PRG_BASE;
					if (!info.header_ok) begin
						state <= LOAD_ERROR;
					end else if (prg_bytes != '0) begin
						state      <= LOAD_PRG;
						bytes_left <= prg_bytes;
					end else if (chr_bytes != '0) begin
						state      <= LOAD_CHR;
						bytes_left <= chr_bytes;
						mem_addr   <= `CHR_BASE;
					end else begin
						state <= LOAD_DONE; // Empty image
					end
				end
				LOAD_PRG, LOAD_CHR: if (byte_strobe) begin
					bytes_left <= bytes_left - 22'd1;
					mem_addr   <= mem_addr + 22'd1;
					if (bytes_left == 22'd1) begin
						if (state == LOAD_PRG && chr_bytes != '0) begin
							state      <= LOAD_CHR;
							bytes_left <= chr_bytes;
							mem_addr   <= `CHR_BASE;
						end else begin
							state <= LOAD_DONE;
						end
					end
				end
				default: ; // Done or error until next reset
			endcase
		end
	end

	assign mem_write = byte_strobe && (state == LOAD_PRG || state == LOAD_CHR);
	assign mem_data  = byte_data;
	assign busy      = (state == LOAD_PRG) || (state == LOAD_CHR);
	assign done      = (state == LOAD_DONE) || (state == LOAD_ERROR);
	assign error     = (state == LOAD_ERROR);

	// Nothing is written for a rejected header
	a_write_after_good_header: assert property (@(posedge clk) disable iff (reset_nes)
		mem_write |-> info.header_ok);

	// Writes stay inside the region sized by the header
	a_addr_in_region: assert property (@(posedge clk) disable iff (reset_nes)
		mem_write |-> ((state == LOAD_PRG) ? (mem_addr_t'(mem_addr - `PRG_BASE) < prg_bytes)
		                                   : (mem_addr_t'(mem_addr - `CHR_BASE) < chr_bytes)));

endmodule

`default_nettype wire

// File: verilog/rom_pkg.sv
/*
 * Types shared by the iNES header parser, the ROM loader and the top level
 */
`default_nettype none

package rom_pkg;

	typedef logic [7:0]  rom_byte_t;
	typedef logic [21:0] mem_addr_t;
	typedef logic [21:0] byte_count_t;   // Bytes still to come in a region
	typedef logic [7:0]  page_count_t;
	typedef logic [2:0]  size_code_t;    // log2 of the region size in pages
	typedef logic [31:0] mapper_flags_t;

	// Loader progress through one image
	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_DONE,
		LOAD_ERROR
	} load_state_t;

endpackage

`default_nettype wire
